/* logic/priv_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~
// CSR window bases and PMA reset table
// Region word is {cfg_1, cfg_0} with one byte per half
// ~~~~~~~~~~~~~~~~~~~~
`ifndef PRIV_CFG_SVH
`define PRIV_CFG_SVH

// Custom CSR windows of 16 and 3 entries
`define PMA_CSR_BASE 12'hBC0
`define CNT_CSR_BASE 12'hBD0

// Half-region byte is {R, W, X, acc_width[1:0], 3'b000}
// E8 RWX half, D0 RW word, C8 RW half, C0 RW byte
// B0 RX word, 88 R half, 80 R byte, 00 no access
`define PMA_DEFAULT_0  16'hB0B0
`define PMA_DEFAULT_1  16'hE8E8
`define PMA_DEFAULT_2  16'hD0D0
`define PMA_DEFAULT_3  16'hD0C8
`define PMA_DEFAULT_4  16'hC088
`define PMA_DEFAULT_5  16'h00D0
`define PMA_DEFAULT_6  16'hE8B0
`define PMA_DEFAULT_7  16'hD000
`define PMA_DEFAULT_8  16'h8888
`define PMA_DEFAULT_9  16'hE8D0
`define PMA_DEFAULT_10 16'hB0D0
`define PMA_DEFAULT_11 16'h80C0
`define PMA_DEFAULT_12 16'hD0E8
`define PMA_DEFAULT_13 16'h0000
`define PMA_DEFAULT_14 16'hC8D0
`define PMA_DEFAULT_15 16'hD0D0

`endif

/* logic/priv_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared types of the PMA subsystem
// Access width codes are ordered, larger code means wider access
// ~~~~~~~~~~~~~~~~~~~~
package priv_pkg;

  // Access width, compared as unsigned
  typedef enum logic [1:0] {
    ACC_BYTE = 2'd0,
    ACC_HALF = 2'd1,
    ACC_WORD = 2'd2
  } acc_width_e;

  // One half-region, 8 bits
  typedef struct packed {
    logic       R;
    logic       W;
    logic       X;
    acc_width_e acc_width;
    logic [2:0] reserved;
  } pma_cfg_t;

  // One region, upper half first
  typedef struct packed {
    pma_cfg_t pma_cfg_1;
    pma_cfg_t pma_cfg_0;
  } pma_reg_t;

  // Memory access, 37 bits
  typedef struct packed {
    logic [31:0] addr;
    logic        ren;
    logic        wen;
    logic        xen;
    acc_width_e  acc_width;
  } mem_req_t;

  typedef struct packed {
    logic l_fault;
    logic s_fault;
    logic i_fault;
  } pma_fault_t;

  // CSR request, active is the write strobe
  typedef struct packed {
    logic [11:0] addr;
    logic        active;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic        ack;
    logic        invalid_csr;
    logic [31:0] rdata;
  } csr_rsp_t;

  // Standard mcause codes for access faults
  typedef enum logic [3:0] {
    EXC_INSTR_ACCESS = 4'd1,
    EXC_LOAD_ACCESS  = 4'd5,
    EXC_STORE_ACCESS = 4'd7
  } exc_cause_e;

endpackage

/* logic/pma_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Read-only region table, loaded from the cfg defaults on reset
// Width fault replaces any permission fault, so at most one flag is set
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "priv_cfg.svh"

module pma_checker
  import priv_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  mem_req_t   mem_req,
  input  logic [11:0] csr_addr,
  output pma_fault_t pma_fault,
  output csr_rsp_t   pma_rsp
);

  localparam logic [11:0] PMA_BASE = `PMA_CSR_BASE;

  // Reset image of the table, entry 0 in the low bits
  localparam pma_reg_t [15:0] PMA_DEFAULTS = {
    `PMA_DEFAULT_15, `PMA_DEFAULT_14, `PMA_DEFAULT_13, `PMA_DEFAULT_12,
    `PMA_DEFAULT_11, `PMA_DEFAULT_10, `PMA_DEFAULT_9,  `PMA_DEFAULT_8,
    `PMA_DEFAULT_7,  `PMA_DEFAULT_6,  `PMA_DEFAULT_5,  `PMA_DEFAULT_4,
    `PMA_DEFAULT_3,  `PMA_DEFAULT_2,  `PMA_DEFAULT_1,  `PMA_DEFAULT_0
  };

  pma_reg_t [15:0] pma_regs;
  pma_reg_t        active_reg;
  pma_cfg_t        pma_cfg;
  pma_fault_t      perm_fault;
  pma_fault_t      width_fault;
  logic            win_hit;

  // No write path, contents only change on reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pma_regs <= PMA_DEFAULTS;
    end
  end

  // CSR read window, 16 entries
  assign win_hit = (csr_addr[11:4] == PMA_BASE[11:4]);

  always_comb begin
    pma_rsp             = '0;
    pma_rsp.ack         = win_hit;
    // Never invalid here, the mux decides that
    pma_rsp.invalid_csr = 1'b0;
    if (win_hit) begin
      pma_rsp.rdata = {16'h0000, pma_regs[csr_addr[3:0]]};
    end
  end

  // Region by top nibble, half by bit 27
  always_comb begin
    active_reg = pma_regs[mem_req.addr[31:28]];
    if (mem_req.addr[27]) begin
      pma_cfg = active_reg.pma_cfg_1;
    end else begin
      pma_cfg = active_reg.pma_cfg_0;
    end
  end

  // Permission check, first missing right wins
  always_comb begin
    perm_fault = '0;
    if (mem_req.ren && !pma_cfg.R) begin
      perm_fault.l_fault = 1'b1;
    end else if (mem_req.wen && !pma_cfg.W) begin
      perm_fault.s_fault = 1'b1;
    end else if (mem_req.xen && !pma_cfg.X) begin
      perm_fault.i_fault = 1'b1;
    end
  end

  // Width check, charged to the first asserted strobe
  always_comb begin
    width_fault = '0;
    if (mem_req.acc_width > pma_cfg.acc_width) begin
      if (mem_req.ren) begin
        width_fault.l_fault = 1'b1;
      end else if (mem_req.wen) begin
        width_fault.s_fault = 1'b1;
      end else if (mem_req.xen) begin
        width_fault.i_fault = 1'b1;
      end
    end
  end

  assign pma_fault = (width_fault != '0) ? width_fault : perm_fault;

  // One cause per access, the cause register relies on it
  a_fault_onehot : assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(pma_fault));

endmodule

/* logic/fault_counter_ext.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Three 32-bit fault counters at CNT_CSR_BASE + 0..2, wrapping
// A CSR write wins over a same-cycle increment
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "priv_cfg.svh"

module fault_counter_ext
  import priv_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  csr_req_t   csr_req,
  input  pma_fault_t pma_fault,
  output csr_rsp_t   cnt_rsp
);

  localparam logic [11:0] CNT_BASE = `CNT_CSR_BASE;

  logic [2:0][31:0] cnt;
  logic [2:0]       fault_vec;
  logic [1:0]       cnt_idx;
  logic             hit;

  // Index 0 load, 1 store, 2 fetch
  assign fault_vec = {pma_fault.i_fault, pma_fault.s_fault, pma_fault.l_fault};
  assign cnt_idx   = csr_req.addr[1:0];

  // Offset 3 of the aligned block is not claimed
  assign hit = (csr_req.addr[11:2] == CNT_BASE[11:2]) && (cnt_idx != 2'd3);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (csr_req.active && hit && (cnt_idx == 2'(i))) begin
          cnt[i] <= csr_req.wdata;
        end else if (fault_vec[i]) begin
          cnt[i] <= cnt[i] + 32'd1;
        end
      end
    end
  end

  always_comb begin
    cnt_rsp             = '0;
    cnt_rsp.ack         = hit;
    cnt_rsp.invalid_csr = 1'b0;
    if (hit) begin
      cnt_rsp.rdata = cnt[cnt_idx];
    end
  end

  // Mux ORs data, an idle extension must stay quiet
  a_rdata_quiet : assert property (@(posedge CLK) disable iff (!nRST)
    !cnt_rsp.ack |-> (cnt_rsp.rdata == '0));

endmodule

/* logic/csr_ext_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Extension windows must not overlap
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_ext_mux
  import priv_pkg::*;
(
  input  csr_rsp_t pma_rsp,
  input  csr_rsp_t cnt_rsp,
  output csr_rsp_t csr_rsp
);

  logic [31:0] pma_data;
  logic [31:0] cnt_data;
  logic        any_ack;

  // Gate each extension by its own ack
  assign pma_data = pma_rsp.ack ? pma_rsp.rdata : 32'h0;
  assign cnt_data = cnt_rsp.ack ? cnt_rsp.rdata : 32'h0;
  assign any_ack  = pma_rsp.ack | cnt_rsp.ack;

  always_comb begin
    csr_rsp.ack = any_ack;
    // Unclaimed address, nobody answers
    csr_rsp.invalid_csr = !any_ack;
    csr_rsp.rdata = pma_data | cnt_data;
  end

  // Overlapping windows would merge two data words
  always_comb begin
    a_one_ack : assert (!(pma_rsp.ack && cnt_rsp.ack));
  end

endmodule

/* logic/fault_cause.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Expects one-hot faults; cause and tval hold until the next fault
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fault_cause
  import priv_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  pma_fault_t  pma_fault,
  input  logic [31:0] fault_addr,
  output logic        cause_valid,
  output exc_cause_e  cause,
  output logic [31:0] tval
);

  exc_cause_e nxt_cause;
  logic       any_fault;

  assign any_fault = pma_fault.l_fault | pma_fault.s_fault | pma_fault.i_fault;

  // Encode fault flag to mcause code
  always_comb begin
    nxt_cause = EXC_LOAD_ACCESS;
    if (pma_fault.s_fault) begin
      nxt_cause = EXC_STORE_ACCESS;
    end else if (pma_fault.i_fault) begin
      nxt_cause = EXC_INSTR_ACCESS;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cause_valid <= 1'b0;
      cause       <= EXC_LOAD_ACCESS;
      tval        <= '0;
    end else begin
      // Single-cycle pulse per faulting access
      cause_valid <= any_fault;
      if (any_fault) begin
        cause <= nxt_cause;
        tval  <= fault_addr;
      end
    end
  end

endmodule

/* logic/priv_pma_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// PMA checker, fault counters and cause register
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module priv_pma_top
  import priv_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  mem_req_t    mem_req,
  input  csr_req_t    csr_req,
  output pma_fault_t  pma_fault,
  output csr_rsp_t    csr_rsp,
  output logic        cause_valid,
  output exc_cause_e  cause,
  output logic [31:0] tval
);

  // Per-extension CSR responses
  csr_rsp_t pma_rsp;
  csr_rsp_t cnt_rsp;

  pma_checker i_pma_checker (
    .CLK       (CLK),
    .nRST      (nRST),
    .mem_req   (mem_req),
    .csr_addr  (csr_req.addr),
    .pma_fault (pma_fault),
    .pma_rsp   (pma_rsp)
  );

  fault_counter_ext i_fault_counter_ext (
    .CLK       (CLK),
    .nRST      (nRST),
    .csr_req   (csr_req),
    .pma_fault (pma_fault),
    .cnt_rsp   (cnt_rsp)
  );

  csr_ext_mux i_csr_ext_mux (
    .pma_rsp (pma_rsp),
    .cnt_rsp (cnt_rsp),
    .csr_rsp (csr_rsp)
  );

  // Trap value is the faulting access address
  fault_cause i_fault_cause (
    .CLK         (CLK),
    .nRST        (nRST),
    .pma_fault   (pma_fault),
    .fault_addr  (mem_req.addr),
    .cause_valid (cause_valid),
    .cause       (cause),
    .tval        (tval)
  );

endmodule

/* sim/tb_clk.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Free-running clock, starts low
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clk #(
  parameter int PERIOD_NS = 40
) (
  output logic CLK
);

  // Half period per toggle
  initial CLK = 1'b0;
  always #(PERIOD_NS / 2) CLK = ~CLK;

endmodule

/* sim/priv_pma_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Model of the region table, counters and cause register
// Compares on the falling edge, then steps the model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "priv_cfg.svh"

module priv_pma_chk
  import priv_pkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  input  mem_req_t    mem_req,
  input  csr_req_t    csr_req,
  input  pma_fault_t  pma_fault,
  input  csr_rsp_t    csr_rsp,
  input  logic        cause_valid,
  input  exc_cause_e  cause,
  input  logic [31:0] tval,
  output int          n_checks,
  output int          fault_errs,
  output int          csr_errs,
  output int          cause_errs
);

  // Region words straight from the cfg header
  localparam logic [15:0] REGIONS [16] = '{
    `PMA_DEFAULT_0,  `PMA_DEFAULT_1,  `PMA_DEFAULT_2,  `PMA_DEFAULT_3,
    `PMA_DEFAULT_4,  `PMA_DEFAULT_5,  `PMA_DEFAULT_6,  `PMA_DEFAULT_7,
    `PMA_DEFAULT_8,  `PMA_DEFAULT_9,  `PMA_DEFAULT_10, `PMA_DEFAULT_11,
    `PMA_DEFAULT_12, `PMA_DEFAULT_13, `PMA_DEFAULT_14, `PMA_DEFAULT_15
  };

  logic [31:0] cnt_m [3];
  logic        cause_valid_m;
  exc_cause_e  cause_m;
  logic [31:0] tval_m;
  // tval only checked once a fault has loaded it
  logic        tval_known;

  // Width limit first, then R, W, X in that order
  function automatic pma_fault_t expect_fault(input mem_req_t req);
    logic [15:0] region;
    logic [7:0]  half;
    pma_fault_t  f;
    region = REGIONS[req.addr[31:28]];
    half   = req.addr[27] ? region[15:8] : region[7:0];
    f      = '0;
    if (req.acc_width > half[4:3]) begin
      f.l_fault = req.ren;
      f.s_fault = req.wen && !req.ren;
      f.i_fault = req.xen && !req.ren && !req.wen;
    end else begin
      f.l_fault = req.ren && !half[7];
      f.s_fault = !f.l_fault && req.wen && !half[6];
      f.i_fault = !f.l_fault && !f.s_fault && req.xen && !half[5];
    end
    return f;
  endfunction

  function automatic csr_rsp_t expect_rsp(input logic [11:0] addr);
    csr_rsp_t    rsp;
    logic [11:0] pma_off;
    logic [11:0] cnt_off;
    pma_off = addr - `PMA_CSR_BASE;
    cnt_off = addr - `CNT_CSR_BASE;
    rsp     = '0;
    if (pma_off < 12'd16) begin
      rsp.ack   = 1'b1;
      rsp.rdata = {16'h0000, REGIONS[pma_off[3:0]]};
    end else if (cnt_off < 12'd3) begin
      rsp.ack   = 1'b1;
      rsp.rdata = cnt_m[cnt_off[1:0]];
    end else begin
      rsp.invalid_csr = 1'b1;
    end
    return rsp;
  endfunction

  task automatic compare_outputs();
    pma_fault_t exp_f;
    csr_rsp_t   exp_rsp;
    exp_f   = expect_fault(mem_req);
    exp_rsp = expect_rsp(csr_req.addr);
    n_checks++;
    if (pma_fault != exp_f) begin
      fault_errs++;
      $display("error %0t: pma_fault %b, expected %b, addr %h", $time,
               pma_fault, exp_f, mem_req.addr);
    end
    if (csr_rsp != exp_rsp) begin
      csr_errs++;
      $display("error %0t: CSR %h ack/invalid/rdata %b/%b/%h, expected %b/%b/%h",
               $time, csr_req.addr, csr_rsp.ack, csr_rsp.invalid_csr, csr_rsp.rdata,
               exp_rsp.ack, exp_rsp.invalid_csr, exp_rsp.rdata);
    end
    if (cause_valid != cause_valid_m || cause != cause_m || (tval_known && tval != tval_m)) begin
      cause_errs++;
      $display("error %0t: cause_valid/cause/tval %b/%0d/%h, expected %b/%0d/%h", $time,
               cause_valid, cause, tval, cause_valid_m, cause_m, tval_m);
    end
  endtask

  // Registers as the DUT will hold them after the next rising edge
  task automatic step_model();
    pma_fault_t  f;
    logic [2:0]  fault_vec;
    logic [11:0] cnt_off;
    f         = expect_fault(mem_req);
    fault_vec = {f.i_fault, f.s_fault, f.l_fault};
    cnt_off   = csr_req.addr - `CNT_CSR_BASE;
    for (int i = 0; i < 3; i++) begin
      // Write beats the increment
      if (csr_req.active && cnt_off == 12'(i)) begin
        cnt_m[i] = csr_req.wdata;
      end else if (fault_vec[i]) begin
        cnt_m[i] = cnt_m[i] + 32'd1;
      end
    end
    cause_valid_m = (f != '0);
    if (f != '0) begin
      tval_m     = mem_req.addr;
      tval_known = 1'b1;
      if (f.l_fault) begin
        cause_m = EXC_LOAD_ACCESS;
      end else if (f.s_fault) begin
        cause_m = EXC_STORE_ACCESS;
      end else begin
        cause_m = EXC_INSTR_ACCESS;
      end
    end
  endtask

  always @(negedge CLK) begin
    if (!nRST) begin
      cnt_m         = '{default: 32'h0};
      cause_valid_m = 1'b0;
      cause_m       = EXC_LOAD_ACCESS;
      tval_m        = '0;
      tval_known    = 1'b0;
      n_checks      = 0;
      fault_errs    = 0;
      csr_errs      = 0;
      cause_errs    = 0;
    end else begin
      compare_outputs();
      step_model();
    end
  end

endmodule

/* sim/priv_pma_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Random accesses and CSR traffic from a fixed LFSR seed
// Outputs are compared in priv_pma_chk on the falling edge
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "priv_cfg.svh"

module priv_pma_tb
  import priv_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int DIR_CYCLES  = 19;
  localparam int RAND_CYCLES = 3000;
  // Three trailing idle cycles for the last registered results
  localparam int RUN_CYCLES  = RST_CYCLES + DIR_CYCLES + RAND_CYCLES + 3;
  localparam int TIMEOUT_NS  = RUN_CYCLES * CLK_PERIOD * 6 / 5;

  logic        CLK;
  logic        nRST;
  mem_req_t    mem_req;
  csr_req_t    csr_req;
  pma_fault_t  pma_fault;
  csr_rsp_t    csr_rsp;
  logic        cause_valid;
  exc_cause_e  cause;
  logic [31:0] tval;
  logic [31:0] lfsr;
  logic        readback;
  logic [11:0] wr_addr;
  int          n_checks;
  int          fault_errs;
  int          csr_errs;
  int          cause_errs;

  tb_clk #(.PERIOD_NS(CLK_PERIOD)) i_tb_clk (.CLK(CLK));

  priv_pma_top i_priv_pma_top (
    .CLK         (CLK),
    .nRST        (nRST),
    .mem_req     (mem_req),
    .csr_req     (csr_req),
    .pma_fault   (pma_fault),
    .csr_rsp     (csr_rsp),
    .cause_valid (cause_valid),
    .cause       (cause),
    .tval        (tval)
  );

  priv_pma_chk i_priv_pma_chk (
    .CLK         (CLK),
    .nRST        (nRST),
    .mem_req     (mem_req),
    .csr_req     (csr_req),
    .pma_fault   (pma_fault),
    .csr_rsp     (csr_rsp),
    .cause_valid (cause_valid),
    .cause       (cause),
    .tval        (tval),
    .n_checks    (n_checks),
    .fault_errs  (fault_errs),
    .csr_errs    (csr_errs),
    .cause_errs  (cause_errs)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic drive_random();
    mem_req_t    req;
    csr_req_t    creq;
    logic [31:0] r;
    logic [11:0] off;
    req.addr = take_bits(32);
    r = take_bits(5);
    req.ren = r[0];
    req.wen = r[1];
    req.xen = r[2];
    case (r[4:3])
      2'd0: req.acc_width = ACC_BYTE;
      2'd1: req.acc_width = ACC_HALF;
      default: req.acc_width = ACC_WORD;
    endcase
    if (readback) begin
      // Counter written last cycle, read it back
      creq     = '{addr: wr_addr, active: 1'b0, wdata: 32'h0};
      readback = 1'b0;
    end else begin
      r = take_bits(14);
      // Half to the PMA window, a quarter each to counters and anywhere
      case (r[13:12])
        2'd1: creq.addr = `CNT_CSR_BASE + {10'h000, r[1:0]};
        2'd2: creq.addr = r[11:0];
        default: creq.addr = `PMA_CSR_BASE + {8'h00, r[3:0]};
      endcase
      creq.active = (take_bits(2) == 32'd0);
      creq.wdata  = take_bits(32);
      off         = creq.addr - `CNT_CSR_BASE;
      readback    = creq.active && (off < 12'd3);
      wr_addr     = creq.addr;
    end
    mem_req <= req;
    csr_req <= creq;
  endtask

  initial begin
    lfsr     = 32'h3cfd_db35;
    readback = 1'b0;
    wr_addr  = '0;
    nRST     = 1'b0;
    mem_req  = '0;
    csr_req  = '0;
    repeat (RST_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    // Reset image: every region, then the three counters
    for (int i = 0; i < DIR_CYCLES; i++) begin
      @(posedge CLK);
      csr_req.addr <= (i < 16) ? `PMA_CSR_BASE + 12'(i) : `CNT_CSR_BASE + 12'(i - 16);
    end
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge CLK);
      drive_random();
    end
    @(posedge CLK);
    mem_req <= '0;
    csr_req <= '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    #1;
    $display("Checks %0d, fault errors %0d, CSR errors %0d, cause errors %0d",
             n_checks, fault_errs, csr_errs, cause_errs);
    if (n_checks > 0 && fault_errs + csr_errs + cause_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog, run length plus 20 percent
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
logic/priv_pkg.sv
logic/pma_checker.sv
logic/fault_counter_ext.sv
logic/csr_ext_mux.sv
logic/fault_cause.sv
logic/priv_pma_top.sv
sim/tb_clk.sv
sim/priv_pma_chk.sv
sim/priv_pma_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PMA testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/1ps --top-module priv_pma_tb \
    -Mdir obj_dir -f flist.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vpriv_pma_tb); then
  echo "$out"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
